/* list.f */
common/rvv_pkg.sv
hw/insn_decoder.sv
hw/cfg_unit.sv
hw/issue_ctrl.sv
hw/vec_regfile.sv
hw/valu/valu.sv
hw/store_port.sv
hw/rvv_core.sv
bench/tb_rvv_core.sv

/* Bender.yml */
package:
  name: rvv_core

sources:
  - common/rvv_pkg.sv
  - hw/insn_decoder.sv
  - hw/cfg_unit.sv
  - hw/issue_ctrl.sv
  - hw/vec_regfile.sv
  - hw/valu/valu.sv
  - hw/store_port.sv
  - hw/rvv_core.sv
  - target: test
    files:
      - bench/tb_rvv_core.sv

/* bench/tb_rvv_core.sv */
module tb_rvv_core;
    localparam int wait_limit = 300;   // cycles per wait loop

    logic                   clk;
    logic                   rst_n;
    rvv_pkg::insn_u         insn;
    logic                   insn_valid;
    logic [31:0]            scalar_rs1;
    logic                   proc_rdy;
    logic [31:0]            scalar_out;
    logic                   scalar_valid;
    rvv_pkg::store_beat_t   store;

    integer     seed;
    int         errors;
    int         tests;
    int         passed;
    int         test_err;
    logic [1:0] cur_sew;
    logic [8:0] cur_vl;
    logic [7:0] shadow [32][32];   // register, byte

    rvv_core dut_i (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .scalar_rs1(scalar_rs1), .proc_rdy(proc_rdy), .scalar_out(scalar_out),
        .scalar_valid(scalar_valid), .store(store)
    );

    always #5 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #1;                        // drive and sample just after the edge
    endtask

    task automatic abort_run(input string why);
        $display("run stopped at %0t: %s", $time, why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_err) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - test_err);
        end
        test_err = errors;
    endtask

    function automatic logic [31:0] enc_cfg(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [10:0] zimm);
        return {1'b0, zimm, rs1, rvv_pkg::funct3_cfg, rd, rvv_pkg::opc_opv};
    endfunction

    function automatic logic [31:0] enc_op(input logic [5:0] f6, input logic [2:0] f3,
                                           input logic [4:0] vd, input logic [4:0] vs2,
                                           input logic [4:0] src);
        return {f6, 1'b1, vs2, src, f3, vd, rvv_pkg::opc_opv};
    endfunction

    function automatic logic [31:0] enc_store(input logic [4:0] vs3);
        return {6'd0, 1'b1, 5'd0, 5'd1, 3'b111, vs3, rvv_pkg::opc_store};   // unit-stride
    endfunction

    function automatic logic [63:0] get_elem(input int r, input int i, input logic [1:0] sew);
        logic [63:0] v;
        int          ew;
        ew = 1 << sew;
        v  = '0;
        for (int b = 0; b < ew; b++) begin
            v[b*8 +: 8] = shadow[r][i*ew + b];
        end
        return v;
    endfunction

    // hold the word until the core takes it
    task automatic send_insn(input logic [31:0] word, input logic [31:0] rs1);
        int cnt;
        insn       = word;
        scalar_rs1 = rs1;
        insn_valid = 1'b1;
        cnt        = 0;
        while (!proc_rdy) begin
            tick();
            cnt++;
            if (cnt > wait_limit) abort_run("instruction was never accepted");
        end
        tick();
        insn_valid = 1'b0;
    endtask

    task automatic set_cfg(input logic [4:0] rd, input logic [4:0] rs1, input logic [2:0] vsew,
                           input logic [2:0] vlmul, input logic [31:0] avl);
        logic [8:0] vlmax;
        logic [8:0] exp_vl;
        int         cnt;
        if (vlmul != 3'd0 || vsew > 3'd3) begin
            exp_vl = '0;                        // vill, sew stays
        end else begin
            vlmax = 9'd32 >> vsew;
            if (rs1 == 5'd0 && rd != 5'd0) exp_vl = vlmax;
            else if (rs1 == 5'd0) exp_vl = cur_vl;
            else if (avl < vlmax) exp_vl = avl[8:0];
            else exp_vl = vlmax;
            cur_sew = vsew[1:0];
        end
        cur_vl = exp_vl;
        send_insn(enc_cfg(rd, rs1, {5'd0, vsew, vlmul}), avl);
        cnt = 0;
        while (!scalar_valid) begin
            tick();
            cnt++;
            if (cnt > wait_limit) abort_run("no vl returned for vsetvli");
        end
        check_val("scalar_out", 64'(exp_vl), 64'(scalar_out));
        tick();
        check_val("scalar_valid", 64'd0, 64'(scalar_valid));   // single cycle pulse
    endtask

    task automatic run_alu(input logic [5:0] f6, input logic [2:0] f3, input logic [4:0] vd,
                           input logic [4:0] vs2, input logic [4:0] src, input logic [31:0] rs1v);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        int          ew;
        ew = 1 << cur_sew;
        for (int i = 0; i < cur_vl; i++) begin
            a = get_elem(vs2, i, cur_sew);
            if (f3 == rvv_pkg::funct3_ivv) b = get_elem(src, i, cur_sew);
            else if (f3 == rvv_pkg::funct3_ivx) b = {{32{rs1v[31]}}, rs1v};
            else b = {{59{src[4]}}, src};
            case (f6)
                rvv_pkg::f6_add: r = a + b;
                rvv_pkg::f6_sub: r = a - b;
                rvv_pkg::f6_and: r = a & b;
                rvv_pkg::f6_or:  r = a | b;
                default:         r = a ^ b;
            endcase
            for (int k = 0; k < ew; k++) begin
                shadow[vd][i*ew + k] = r[k*8 +: 8];   // only the element's bytes change
            end
        end
        send_insn(enc_op(f6, f3, vd, vs2, src), rs1v);
    endtask

    task automatic run_store(input logic [4:0] vs3, input logic [31:0] base);
        int          nbytes;
        int          n;
        int          k;
        int          cnt;
        logic [63:0] exp_data;
        logic [7:0]  exp_be;
        nbytes = int'(cur_vl) << cur_sew;
        n      = (nbytes + 7) / 8;
        if (n == 0) n = 1;
        send_insn(enc_store(vs3), base);
        k   = 0;
        cnt = 0;
        while (k < n) begin
            if (store.valid) begin
                for (int j = 0; j < 8; j++) begin
                    exp_data[j*8 +: 8] = shadow[vs3][k*8 + j];
                    exp_be[j]          = (k*8 + j) < nbytes;
                end
                check_val("store.addr", 64'(base + 32'(8*k)), 64'(store.addr));
                check_val("store.be", 64'(exp_be), 64'(store.be));
                check_val("store.data", exp_data, store.data);
                k++;
            end
            tick();
            cnt++;
            if (cnt > wait_limit) abort_run("store beats missing");
        end
        check_val("store.valid", 64'd0, 64'(store.valid));   // no extra beat
    endtask

    initial begin
        logic [31:0] base;
        clk        = 1'b0;
        rst_n      = 1'b0;
        insn       = '0;
        insn_valid = 1'b0;
        scalar_rs1 = '0;
        seed       = 32'h2131ec67;
        errors     = 0;
        tests      = 0;
        passed     = 0;
        test_err   = 0;
        cur_sew    = '0;
        cur_vl     = '0;
        for (int r = 0; r < 32; r++) begin
            for (int b = 0; b < 32; b++) shadow[r][b] = 8'h00;
        end

        repeat (16) begin
            tick();
            check_val("proc_rdy", 64'd0, 64'(proc_rdy));
            check_val("scalar_valid", 64'd0, 64'(scalar_valid));
            check_val("store.valid", 64'd0, 64'(store.valid));
        end
        rst_n = 1'b1;
        check_val("proc_rdy", 64'd0, 64'(proc_rdy));
        tick();
        check_val("proc_rdy", 64'd1, 64'(proc_rdy));
        finish_test("reset");

        for (int s = 0; s < 4; s++) set_cfg(5'd1, 5'd5, 3'(s), 3'd0, 32'd300);
        set_cfg(5'd2, 5'd6, 3'd2, 3'd0, 32'd3);
        set_cfg(5'd3, 5'd0, 3'd1, 3'd0, 32'd0);     // rs1 x0 gives vlmax
        set_cfg(5'd4, 5'd7, 3'd1, 3'd0, 32'd5);
        set_cfg(5'd0, 5'd0, 3'd1, 3'd0, 32'd99);    // vl kept at 5
        set_cfg(5'd1, 5'd5, 3'd0, 3'd1, 32'd8);     // lmul 2
        set_cfg(5'd1, 5'd5, 3'd4, 3'd0, 32'd8);     // sew 128
        finish_test("vsetvli");

        for (int s = 0; s < 4; s++) begin
            set_cfg(5'd1, 5'd5, 3'(s), 3'd0, 1 + ($unsigned($random(seed)) % (32 >> s)));
            run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivx, 5'(3 + s), 5'd0, 5'd1, $random(seed));
            base = $random(seed) & 32'hffff_fff8;
            run_store(5'(3 + s), base);
        end
        finish_test("vadd_vx_store");

        for (int p = 0; p < 2; p++) begin
            set_cfg(5'd1, 5'd5, 3'(p*3), 3'd0, 32'd32);
            run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivx, 5'd1, 5'd0, 5'd0, $random(seed));
            run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivx, 5'd2, 5'd0, 5'd0, $random(seed));
            // one or two beats per op, so each result is still in flight when the next reads it
            set_cfg(5'd1, 5'd5, 3'(p*3), 3'd0, 32'd2);
            run_alu(rvv_pkg::f6_xor, rvv_pkg::funct3_ivx, 5'd1, 5'd1, 5'd0, $random(seed));
            run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivv, 5'd4, 5'd1, 5'd2, 32'd0);
            run_alu(rvv_pkg::f6_sub, rvv_pkg::funct3_ivv, 5'd5, 5'd4, 5'd1, 32'd0);
            run_alu(rvv_pkg::f6_and, rvv_pkg::funct3_ivv, 5'd6, 5'd5, 5'd2, 32'd0);
            run_alu(rvv_pkg::f6_or,  rvv_pkg::funct3_ivv, 5'd7, 5'd4, 5'd6, 32'd0);   // waits on vs1
            run_alu(rvv_pkg::f6_xor, rvv_pkg::funct3_ivv, 5'd8, 5'd7, 5'd5, 32'd0);
            set_cfg(5'd1, 5'd5, 3'(p*3), 3'd0, 32'd32);
            for (int r = 4; r <= 8; r++) run_store(5'(r), 32'h1000 + 32'(r*32));
        end
        finish_test("vv_chain");

        set_cfg(5'd1, 5'd5, 3'd1, 3'd0, 32'd16);
        run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivi, 5'd9, 5'd2, 5'b11011, 32'd0);
        run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivi, 5'd10, 5'd2, 5'd7, 32'd0);
        run_alu(rvv_pkg::f6_xor, rvv_pkg::funct3_ivi, 5'd11, 5'd2, 5'b10000, 32'd0);
        run_alu(rvv_pkg::f6_and, rvv_pkg::funct3_ivi, 5'd13, 5'd2, 5'b11110, 32'd0);
        run_store(5'd9, 32'h2000);
        run_store(5'd10, 32'h2040);
        run_store(5'd11, 32'h2080);
        run_store(5'd13, 32'h20c0);
        set_cfg(5'd1, 5'd5, 3'd3, 3'd0, 32'd4);
        run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivi, 5'd14, 5'd0, 5'b11011, 32'd0);
        run_store(5'd14, 32'h2100);
        finish_test("vi_forms");

        set_cfg(5'd1, 5'd5, 3'd0, 3'd0, 32'd32);
        run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivx, 5'd12, 5'd0, 5'd0, 32'h0000_00aa);
        set_cfg(5'd1, 5'd5, 3'd0, 3'd0, 32'd5);
        run_alu(rvv_pkg::f6_add, rvv_pkg::funct3_ivi, 5'd12, 5'd12, 5'd1, 32'd0);
        run_store(5'd12, 32'h3000);                    // short store, partial enables
        set_cfg(5'd1, 5'd5, 3'd0, 3'd0, 32'd32);
        run_store(5'd12, 32'h3040);
        set_cfg(5'd1, 5'd5, 3'd2, 3'd0, 32'd3);
        run_alu(rvv_pkg::f6_xor, rvv_pkg::funct3_ivx, 5'd4, 5'd4, 5'd0, $random(seed));
        set_cfg(5'd1, 5'd5, 3'd2, 3'd0, 32'd8);
        run_store(5'd4, 32'h3080);
        finish_test("tail_undisturbed");

        $display("tests %0d, passed %0d, errors %0d", tests, passed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hw/rvv_core.sv */
module rvv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rvv_pkg::insn_u             insn,
    input  logic                       insn_valid,
    input  logic [rvv_pkg::xlen-1:0]   scalar_rs1,
    output logic                       proc_rdy,
    output logic [rvv_pkg::xlen-1:0]   scalar_out,
    output logic                       scalar_valid,
    output rvv_pkg::store_beat_t       store
);
    rvv_pkg::insn_u                      fetched;
    logic [rvv_pkg::xlen-1:0]            fetched_scalar;
    rvv_pkg::dec_t                       dec;
    rvv_pkg::cfg_t                       cfg;
    logic                                cfg_fire;
    logic [rvv_pkg::vreg_bits-1:0]       rd_addr_1;
    logic [rvv_pkg::vreg_bits-1:0]       rd_addr_2;
    logic [rvv_pkg::beat_bits-1:0]       rd_beat;
    logic [rvv_pkg::data_width-1:0]      rd_data_1;
    logic [rvv_pkg::data_width-1:0]      rd_data_2;
    rvv_pkg::issue_t                     item;
    rvv_pkg::wr_req_t                    wr;

    issue_ctrl issue_i (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .scalar_rs1(scalar_rs1), .proc_rdy(proc_rdy), .fetched(fetched),
        .fetched_scalar(fetched_scalar), .dec(dec), .cfg(cfg), .cfg_fire(cfg_fire),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .rd_beat(rd_beat),
        .item(item), .wr(wr)
    );

    insn_decoder dec_i (.fetched(fetched), .scalar(fetched_scalar), .dec(dec));

    cfg_unit cfg_i (
        .clk(clk), .rst_n(rst_n), .dec(dec), .cfg_fire(cfg_fire), .cfg(cfg),
        .scalar_out(scalar_out), .scalar_valid(scalar_valid)
    );

    vec_regfile rf_i (
        .clk(clk), .rst_n(rst_n), .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
        .rd_beat(rd_beat), .rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .wr(wr)
    );

    valu alu_i (
        .clk(clk), .rst_n(rst_n), .item(item), .rd_data_1(rd_data_1),
        .rd_data_2(rd_data_2), .wr(wr)
    );

    store_port st_i (.clk(clk), .rst_n(rst_n), .item(item), .rd_data_1(rd_data_1), .store(store));

endmodule

/* hw/store_port.sv */
module store_port (
    input  logic                             clk,
    input  logic                             rst_n,
    input  rvv_pkg::issue_t                  item,
    input  logic [rvv_pkg::data_width-1:0]   rd_data_1,
    output rvv_pkg::store_beat_t             store
);
    logic fire;

    assign fire = item.valid & (item.kind == rvv_pkg::kind_store);

    // one beat per cycle, memory side never stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            store <= '0;
        end else begin
            store.valid <= fire;
            store.addr  <= item.addr;
            store.data  <= rd_data_1;
            store.be    <= item.be;    // tail bytes masked off
        end
    end

endmodule

/* hw/valu/valu.sv */
module valu (
    input  logic                             clk,
    input  logic                             rst_n,
    input  rvv_pkg::issue_t                  item,
    input  logic [rvv_pkg::data_width-1:0]   rd_data_1,
    input  logic [rvv_pkg::data_width-1:0]   rd_data_2,
    output rvv_pkg::wr_req_t                 wr
);
    logic [rvv_pkg::data_width-1:0] imm_sx;
    logic [rvv_pkg::data_width-1:0] src_b;
    logic [rvv_pkg::data_width-1:0] res;

    // copy the low element of v into every lane
    function automatic logic [rvv_pkg::data_width-1:0] splat(
        input logic [rvv_pkg::data_width-1:0] v,
        input logic [1:0]                     sew
    );
        case (sew)
            2'd0:    return {8{v[7:0]}};
            2'd1:    return {4{v[15:0]}};
            2'd2:    return {2{v[31:0]}};
            default: return v;
        endcase
    endfunction

    // byte-serial carry chain, restarted at each element boundary
    function automatic logic [rvv_pkg::data_width-1:0] lane_add(
        input logic [rvv_pkg::data_width-1:0] a,
        input logic [rvv_pkg::data_width-1:0] b,
        input logic [1:0]                     sew,
        input logic                           sub
    );
        logic [8:0]                     sum;
        logic                           cy;
        logic [rvv_pkg::data_width-1:0] r;
        cy = 1'b0;
        r  = '0;
        for (int j = 0; j < rvv_pkg::dw_b; j++) begin
            if ((j & ((1 << sew) - 1)) == 0) begin
                cy = sub;   // a - b as a + ~b + 1
            end
            sum = {1'b0, a[j*8 +: 8]} + {1'b0, sub ? ~b[j*8 +: 8] : b[j*8 +: 8]} + 9'(cy);
            r[j*8 +: 8] = sum[7:0];
            cy = sum[8];
        end
        return r;
    endfunction

    assign imm_sx = {{(rvv_pkg::data_width - 5){item.scalar[4]}}, item.scalar[4:0]};

    always_comb begin
        case (item.src_kind)
            rvv_pkg::src_vv: src_b = rd_data_1;
            rvv_pkg::src_vi: src_b = splat(imm_sx, item.sew);
            default:         src_b = splat(item.scalar, item.sew);
        endcase
        case (item.alu_op)
            rvv_pkg::alu_add: res = lane_add(rd_data_2, src_b, item.sew, 1'b0);
            rvv_pkg::alu_sub: res = lane_add(rd_data_2, src_b, item.sew, 1'b1);
            rvv_pkg::alu_and: res = rd_data_2 & src_b;
            rvv_pkg::alu_or:  res = rd_data_2 | src_b;
            default:          res = rd_data_2 ^ src_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr <= '0;
        end else begin
            wr.valid <= item.valid & (item.kind == rvv_pkg::kind_alu);
            wr.vd    <= item.vd;
            wr.beat  <= item.beat;
            wr.last  <= item.last;
            wr.data  <= res;
            wr.be    <= item.be;
        end
    end

endmodule

/* hw/vec_regfile.sv */
module vec_regfile (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [rvv_pkg::vreg_bits-1:0]    rd_addr_1,
    input  logic [rvv_pkg::vreg_bits-1:0]    rd_addr_2,
    input  logic [rvv_pkg::beat_bits-1:0]    rd_beat,
    output logic [rvv_pkg::data_width-1:0]   rd_data_1,
    output logic [rvv_pkg::data_width-1:0]   rd_data_2,
    input  rvv_pkg::wr_req_t                 wr
);
    logic [rvv_pkg::data_width-1:0] mem [rvv_pkg::num_vec][rvv_pkg::beats_per_reg];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < rvv_pkg::num_vec; r++) begin
                for (int b = 0; b < rvv_pkg::beats_per_reg; b++) begin
                    mem[r][b] <= '0;
                end
            end
        end else if (wr.valid) begin
            for (int j = 0; j < rvv_pkg::dw_b; j++) begin
                if (wr.be[j]) begin
                    mem[wr.vd][wr.beat][j*8 +: 8] <= wr.data[j*8 +: 8];   // tail bytes untouched
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_data_1 <= mem[rd_addr_1][rd_beat];
        rd_data_2 <= mem[rd_addr_2][rd_beat];
    end

endmodule

/* hw/issue_ctrl.sv */
module issue_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  rvv_pkg::insn_u                  insn,
    input  logic                            insn_valid,
    input  logic [rvv_pkg::xlen-1:0]        scalar_rs1,
    output logic                            proc_rdy,
    output rvv_pkg::insn_u                  fetched,
    output logic [rvv_pkg::xlen-1:0]        fetched_scalar,
    input  rvv_pkg::dec_t                   dec,
    input  rvv_pkg::cfg_t                   cfg,
    output logic                            cfg_fire,
    output logic [rvv_pkg::vreg_bits-1:0]   rd_addr_1,
    output logic [rvv_pkg::vreg_bits-1:0]   rd_addr_2,
    output logic [rvv_pkg::beat_bits-1:0]   rd_beat,
    output rvv_pkg::issue_t                 item,
    input  rvv_pkg::wr_req_t                wr
);
    logic                              started;
    logic                              busy;       // fetch register holds an instruction
    logic [rvv_pkg::beat_bits-1:0]     beat;
    logic [rvv_pkg::num_vec-1:0]       pending;
    logic [rvv_pkg::num_vec-1:0]       sb_set;
    logic [rvv_pkg::num_vec-1:0]       sb_clr;
    logic [rvv_pkg::vl_bits+2:0]       vl_bytes;
    logic [rvv_pkg::vl_bits+2:0]       n_beats;
    logic                              is_store;
    logic                              is_vec;
    logic                              hazard;
    logic                              go;
    logic                              last;
    logic                              retire;
    rvv_pkg::issue_t                   nxt;

    assign is_store = (dec.kind == rvv_pkg::kind_store);
    assign is_vec   = busy & ((dec.kind == rvv_pkg::kind_alu) | is_store);
    assign cfg_fire = busy & (dec.kind == rvv_pkg::kind_cfg);

    // sources are checked once, before beat 0; a pending vd also holds so that
    // an older last-beat clear cannot drop the new mark
    assign hazard = (beat == '0) & (is_store ? pending[dec.vd]
                  : pending[dec.vs2] | pending[dec.vd]
                  | ((dec.src_kind == rvv_pkg::src_vv) & pending[dec.vs1]));
    assign go     = is_vec & ~hazard;

    assign vl_bytes = (rvv_pkg::vl_bits + 3)'(cfg.vl) << cfg.sew;
    assign n_beats  = (vl_bytes + 7) >> 3;
    assign last     = ((rvv_pkg::vl_bits + 3)'(beat) + 1'b1) >= n_beats;   // n of 0 still issues one beat
    assign retire   = cfg_fire | (busy & (dec.kind == rvv_pkg::kind_none)) | (go & last);
    assign proc_rdy = started & (~busy | retire);

    assign rd_addr_1 = is_store ? dec.vd : dec.vs1;
    assign rd_addr_2 = dec.vs2;
    assign rd_beat   = beat;

    always_comb begin
        sb_set = '0;
        sb_clr = '0;
        sb_set[dec.vd] = go & (beat == '0) & ~is_store;
        sb_clr[wr.vd]  = wr.valid & wr.last;

        nxt          = '0;
        nxt.valid    = go;
        nxt.kind     = dec.kind;
        nxt.alu_op   = dec.alu_op;
        nxt.src_kind = dec.src_kind;
        nxt.sew      = cfg.sew;
        nxt.vd       = dec.vd;
        nxt.beat     = beat;
        nxt.last     = last;
        nxt.addr     = fetched_scalar + rvv_pkg::xlen'(beat) * rvv_pkg::dw_b;
        for (int j = 0; j < rvv_pkg::dw_b; j++) begin
            nxt.be[j] = ((rvv_pkg::vl_bits + 3)'(beat) * rvv_pkg::dw_b + j) < vl_bytes;
        end
        if (dec.src_kind == rvv_pkg::src_vi) begin
            nxt.scalar = rvv_pkg::data_width'(dec.imm);
        end else begin
            nxt.scalar = {{(rvv_pkg::data_width - rvv_pkg::xlen){dec.scalar[rvv_pkg::xlen-1]}},
                          dec.scalar};
        end
    end

    always_ff @(posedge clk) begin
        if (insn_valid && proc_rdy) begin
            fetched        <= insn;
            fetched_scalar <= scalar_rs1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
            busy    <= 1'b0;
            beat    <= '0;
            pending <= '0;
            item    <= '0;
        end else begin
            started <= 1'b1;
            if (insn_valid && proc_rdy) begin
                busy <= 1'b1;
            end else if (retire) begin
                busy <= 1'b0;
            end
            if (go) begin
                beat <= last ? '0 : beat + 1'b1;
            end
            pending <= (pending & ~sb_clr) | sb_set;
            item    <= nxt;      // lines up with the read data one cycle later
        end
    end

endmodule

/* hw/cfg_unit.sv */
module cfg_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rvv_pkg::dec_t              dec,
    input  logic                       cfg_fire,
    output rvv_pkg::cfg_t              cfg,
    output logic [rvv_pkg::xlen-1:0]   scalar_out,
    output logic                       scalar_valid
);
    logic                          vill;
    logic [1:0]                    new_sew;
    logic [rvv_pkg::vl_bits-1:0]   vlmax;
    logic [rvv_pkg::vl_bits-1:0]   new_vl;

    // zimm[2:0] is vlmul and zimm[5:3] is vsew
    assign vill    = (dec.zimm[2:0] != 3'b000) | dec.zimm[5];
    assign new_sew = vill ? cfg.sew : dec.zimm[4:3];
    assign vlmax   = rvv_pkg::vl_bits'(rvv_pkg::vlen / 8) >> new_sew;

    always_comb begin
        if (vill) begin
            new_vl = '0;
        end else if (dec.rs1_zero && !dec.rd_zero) begin
            new_vl = vlmax;
        end else if (dec.rs1_zero) begin
            new_vl = cfg.vl;                          // keep current vl
        end else if (dec.scalar < rvv_pkg::xlen'(vlmax)) begin
            new_vl = rvv_pkg::vl_bits'(dec.scalar);
        end else begin
            new_vl = vlmax;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg          <= '0;
            scalar_out   <= '0;
            scalar_valid <= 1'b0;
        end else begin
            scalar_valid <= cfg_fire;
            if (cfg_fire) begin
                cfg.sew    <= new_sew;
                cfg.vl     <= new_vl;
                scalar_out <= rvv_pkg::xlen'(new_vl);
            end
        end
    end

endmodule

/* hw/insn_decoder.sv */
module insn_decoder (
    input  rvv_pkg::insn_u             fetched,
    input  logic [rvv_pkg::xlen-1:0]   scalar,
    output rvv_pkg::dec_t              dec
);
    logic op_known;
    logic int_form;

    assign int_form = (fetched.opv.funct3 == rvv_pkg::funct3_ivv)
                    | (fetched.opv.funct3 == rvv_pkg::funct3_ivx)
                    | (fetched.opv.funct3 == rvv_pkg::funct3_ivi);

    always_comb begin
        dec          = '0;               // kind none unless matched below
        dec.vd       = fetched.opv.vd;   // vs3 when this is a store
        dec.vs1      = fetched.opv.vs1;
        dec.vs2      = fetched.opv.vs2;
        dec.imm      = fetched.opv.vs1;
        dec.rs1_zero = (fetched.cfg.rs1 == '0);
        dec.rd_zero  = (fetched.cfg.rd == '0);
        dec.zimm     = fetched.cfg.zimm;
        dec.scalar   = scalar;
        op_known     = 1'b1;

        case (fetched.opv.funct6)
            rvv_pkg::f6_add: dec.alu_op = rvv_pkg::alu_add;
            rvv_pkg::f6_sub: dec.alu_op = rvv_pkg::alu_sub;
            rvv_pkg::f6_and: dec.alu_op = rvv_pkg::alu_and;
            rvv_pkg::f6_or:  dec.alu_op = rvv_pkg::alu_or;
            rvv_pkg::f6_xor: dec.alu_op = rvv_pkg::alu_xor;
            default:         op_known   = 1'b0;
        endcase

        case (fetched.opv.funct3)
            rvv_pkg::funct3_ivx: dec.src_kind = rvv_pkg::src_vx;
            rvv_pkg::funct3_ivi: dec.src_kind = rvv_pkg::src_vi;
            default:             dec.src_kind = rvv_pkg::src_vv;
        endcase

        if (fetched.opv.opcode == rvv_pkg::opc_store) begin
            dec.kind = rvv_pkg::kind_store;
        end else if (fetched.opv.opcode == rvv_pkg::opc_opv) begin
            if (fetched.cfg.funct3 == rvv_pkg::funct3_cfg && !fetched.cfg.top) begin
                dec.kind = rvv_pkg::kind_cfg;   // vsetvli, vsetvl stays unsupported
            end else if (op_known && int_form) begin
                dec.kind = rvv_pkg::kind_alu;
            end
        end
    end

endmodule

/* common/rvv_pkg.sv */
package rvv_pkg;

    localparam int vlen          = 256;
    localparam int data_width    = 64;
    localparam int dw_b          = data_width / 8;
    localparam int beats_per_reg = vlen / data_width;   // lmul 1 only
    localparam int beat_bits     = 2;
    localparam int num_vec       = 32;
    localparam int vreg_bits     = 5;
    localparam int xlen          = 32;
    localparam int vl_bits       = 9;                   // room for vl up to 256

    localparam logic [6:0] opc_store = 7'h27;
    localparam logic [6:0] opc_opv   = 7'h57;

    localparam logic [2:0] funct3_ivv = 3'h0;
    localparam logic [2:0] funct3_ivi = 3'h3;
    localparam logic [2:0] funct3_ivx = 3'h4;
    localparam logic [2:0] funct3_cfg = 3'h7;

    localparam logic [5:0] f6_add = 6'h00;
    localparam logic [5:0] f6_sub = 6'h02;
    localparam logic [5:0] f6_and = 6'h09;
    localparam logic [5:0] f6_or  = 6'h0a;
    localparam logic [5:0] f6_xor = 6'h0b;

    // arithmetic and store layout, vd holds vs3 for a store
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;      // also rs1 or simm5
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opv_fmt_t;

    typedef struct packed {
        logic        top;     // 0 selects vsetvli
        logic [10:0] zimm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } cfg_fmt_t;

    typedef union packed {
        opv_fmt_t opv;
        cfg_fmt_t cfg;
    } insn_u;

    typedef enum logic [1:0] {kind_none, kind_cfg, kind_alu, kind_store} insn_kind_e;
    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;
    typedef enum logic [1:0] {src_vv, src_vx, src_vi} src_kind_e;

    typedef struct packed {
        insn_kind_e          kind;
        alu_op_e             alu_op;
        src_kind_e           src_kind;
        logic [4:0]          vd;
        logic [4:0]          vs1;
        logic [4:0]          vs2;
        logic                rs1_zero;
        logic                rd_zero;
        logic [4:0]          imm;
        logic [10:0]         zimm;
        logic [xlen-1:0]     scalar;
    } dec_t;

    typedef struct packed {
        logic [1:0]          sew;
        logic [vl_bits-1:0]  vl;
    } cfg_t;

    typedef struct packed {
        logic                  valid;
        insn_kind_e            kind;
        alu_op_e               alu_op;
        src_kind_e             src_kind;
        logic [1:0]            sew;
        logic [vreg_bits-1:0]  vd;
        logic [beat_bits-1:0]  beat;
        logic                  last;
        logic [dw_b-1:0]       be;
        logic [data_width-1:0] scalar;   // rs1 or raw simm5
        logic [xlen-1:0]       addr;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [vreg_bits-1:0]  vd;
        logic [beat_bits-1:0]  beat;
        logic                  last;
        logic [data_width-1:0] data;
        logic [dw_b-1:0]       be;
    } wr_req_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       addr;
        logic [data_width-1:0] data;
        logic [dw_b-1:0]       be;
    } store_beat_t;

endpackage
